//--- include/gf_cfg.svh
// GF(2^163) multiplier configuration: field size, digit size and reduction taps
`ifndef GF_CFG_SVH
`define GF_CFG_SVH

// Degree of the field polynomial x^163 + x^7 + x^6 + x^3 + 1
`define GF_M 163

// Bits of the multiplier consumed per cycle
`define GF_DIGIT 4

// Digits per multiplier operand, rounded up so the top digit is partial
`define GF_NUM_DIGITS ((`GF_M + `GF_DIGIT - 1) / `GF_DIGIT)

// Low terms of the field polynomial, so that x^163 == GF_POLY_TAPS in the field
// Bits 7, 6, 3 and 0 are set
`define GF_POLY_TAPS {{(`GF_M - 8){1'b0}}, 8'b1100_1001}

`endif

//--- design/gf_pkg.sv
// GF(2^163) multiplier package with the element, digit, product and counter types
`include "gf_cfg.svh"

package gf_pkg;

  // One element of the field, coefficient i is bit i
  typedef logic [`GF_M-1:0] gf_elem_t;

  // One digit of the multiplier operand
  typedef logic [`GF_DIGIT-1:0] gf_digit_t;

  // Element times digit before reduction, degree up to M + DIGIT - 2
  typedef logic [`GF_M+`GF_DIGIT-2:0] gf_wide_t;

  // Digit index, wide enough to count one past the last digit
  typedef logic [$clog2(`GF_NUM_DIGITS+1)-1:0] gf_count_t;

endpackage

//--- design/gf_digit_if.sv
// Digit stream from the operand sequencer to the multiply-accumulate stage
`timescale 1ns/1ps

interface gf_digit_if
  import gf_pkg::*;
(
  input logic clk
);

  gf_digit_t digit;  // Current digit of b
  logic      step;   // One digit to consume on this edge
  logic      first;  // Accumulator starts from zero at this step
  logic      last;   // Final digit, result is ready after this step
  gf_elem_t  opa;    // Multiplicand captured at the start edge

  modport seq (
    input  clk,
    output digit,
    output step,
    output first,
    output last,
    output opa
  );

  modport mac (
    input clk,
    input digit,
    input step,
    input first,
    input last,
    input opa
  );

endinterface

//--- design/gf_digit_sequencer.sv
// Operand sequencer that captures a and b and issues the digits of b from the top
`timescale 1ns/1ps
`include "gf_cfg.svh"

module gf_digit_sequencer
  import gf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  gf_elem_t a,
  input  gf_elem_t b,
  gf_digit_if.seq  dig
);

  localparam int        DW       = `GF_DIGIT;
  localparam int        PAD_W    = `GF_NUM_DIGITS * `GF_DIGIT;
  localparam gf_count_t LAST_IDX = gf_count_t'(`GF_NUM_DIGITS - 1);
  localparam gf_count_t END_IDX  = gf_count_t'(`GF_NUM_DIGITS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_HOLD
  } state_t;

  state_t           state;
  gf_count_t        cnt;    // Index of the next digit to issue
  logic [PAD_W-1:0] b_pad;
  logic [PAD_W-1:0] b_sh;   // Remaining digits, next one at the top

  // The top digit is partial and gets zero-filled above bit 162
  assign b_pad = PAD_W'(b);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      cnt       <= '0;
      dig.step  <= 1'b0;
      dig.first <= 1'b0;
      dig.last  <= 1'b0;
    end else if (!start) begin
      // Dropping start abandons whatever is in progress
      state     <= ST_IDLE;
      cnt       <= '0;
      dig.step  <= 1'b0;
      dig.first <= 1'b0;
      dig.last  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          state     <= ST_RUN;
          cnt       <= gf_count_t'(1);  // Digit 0 goes out on this edge
          dig.step  <= 1'b1;
          dig.first <= 1'b1;
          dig.last  <= (LAST_IDX == '0);
        end
        ST_RUN: begin
          if (cnt == END_IDX) begin
            // The MAC takes the last digit on this edge
            state     <= ST_HOLD;
            dig.step  <= 1'b0;
            dig.first <= 1'b0;
            dig.last  <= 1'b0;
          end else begin
            cnt       <= cnt + gf_count_t'(1);
            dig.step  <= 1'b1;
            dig.first <= 1'b0;
            dig.last  <= (cnt == LAST_IDX);
          end
        end
        ST_HOLD: begin
          // Wait here until start is released
          dig.step  <= 1'b0;
          dig.first <= 1'b0;
          dig.last  <= 1'b0;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && state == ST_IDLE) begin
      dig.opa   <= a;
      dig.digit <= b_pad[PAD_W-1 -: DW];
      b_sh      <= b_pad << DW;
    end else if (start && state == ST_RUN) begin
      dig.digit <= b_sh[PAD_W-1 -: DW];
      b_sh      <= b_sh << DW;
    end
  end

endmodule

//--- design/gf_poly_reduce.sv
// Folds an unreduced product back into a field element modulo the field polynomial
`timescale 1ns/1ps
`include "gf_cfg.svh"

module gf_poly_reduce
  import gf_pkg::*;
(
  input  gf_wide_t wide,
  output gf_elem_t elem
);

  localparam int       M    = `GF_M;
  localparam int       OVF  = `GF_DIGIT - 1;  // Coefficients above degree M-1
  localparam gf_elem_t TAPS = `GF_POLY_TAPS;

  // A coefficient at degree M+k equals x^k times the tap polynomial
  // The taps are of low degree, so the shifted copies never overflow again
  always_comb begin
    elem = wide[M-1:0];
    for (int k = 0; k < OVF; k++) begin
      if (wide[M+k]) begin
        elem = elem ^ (TAPS << k);
      end
    end
  end

endmodule

//--- design/gf_digit_mac.sv
// Digit multiply-accumulate stage holding the result register and the done flag
`timescale 1ns/1ps
`include "gf_cfg.svh"

module gf_digit_mac
  import gf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  gf_digit_if.mac  dig,
  output gf_elem_t p,
  output logic     done
);

  localparam int DW = `GF_DIGIT;

  gf_elem_t acc;        // Running partial result, reduced
  gf_elem_t acc_term;
  gf_wide_t acc_pre;    // Accumulator times x^(DW-1), unreduced
  gf_elem_t acc_pre_r;
  gf_wide_t part;       // Digit times multiplicand
  gf_wide_t sum;
  gf_elem_t acc_next;

  assign acc_term = dig.first ? '0 : acc;

  // A shift by the full digit width does not fit the wide type, so the
  // accumulator is shifted by DW-1, reduced, then shifted once more in the sum
  assign acc_pre = {acc_term, {(DW-1){1'b0}}};

  gf_poly_reduce pre_reduce_i (
    .wide (acc_pre),
    .elem (acc_pre_r)
  );

  always_comb begin
    part = '0;
    for (int i = 0; i < DW; i++) begin
      if (dig.digit[i]) begin
        part = part ^ (gf_wide_t'(dig.opa) << i);
      end
    end
  end

  assign sum = gf_wide_t'({acc_pre_r, 1'b0}) ^ part;

  gf_poly_reduce sum_reduce_i (
    .wide (sum),
    .elem (acc_next)
  );

  always_ff @(posedge clk) begin
    if (start && dig.step) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p    <= '0;
      done <= 1'b0;
    end else if (!start) begin
      done <= 1'b0;  // p keeps the last result
    end else if (dig.step && dig.last) begin
      p    <= acc_next;
      done <= 1'b1;
    end
  end

endmodule

//--- design/gf163_mult.sv
// GF(2^163) digit-serial multiplier, most significant digit of b first
`timescale 1ns/1ps

module gf163_mult
  import gf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,  // Held high for the whole operation
  input  gf_elem_t a,
  input  gf_elem_t b,
  output gf_elem_t p,
  output logic     done    // High from the last digit until start drops
);

  gf_digit_if dig_if (
    .clk (clk)
  );

  gf_digit_sequencer seq_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .a     (a),
    .b     (b),
    .dig   (dig_if.seq)
  );

  gf_digit_mac mac_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .dig   (dig_if.mac),
    .p     (p),
    .done  (done)
  );

endmodule

//--- verification/gf163_mult_chk.sv
// Start and done protocol checker bound to the GF(2^163) multiplier
`timescale 1ns/1ps

module gf163_mult_chk
  import gf_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     start,
  input logic     done,
  input gf_elem_t p
);

  int unsigned fail_cnt = 0;

  // done only comes up after edges that all sampled start high
  done_needs_start: assert property (
    @(posedge clk) disable iff (!rst_n) !$past(start) |-> !done
  ) else begin
    $error("done is high although start was low on the edge before");
    fail_cnt++;
  end

  p_stable_in_done: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> $stable(p)
  ) else begin
    $error("p changed while done was high");
    fail_cnt++;
  end

  // Once up, done follows start with one edge of delay
  done_falls: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> done == $past(start)
  ) else begin
    $error("done did not fall exactly on the edge after start was sampled low");
    fail_cnt++;
  end

endmodule

bind gf163_mult gf163_mult_chk chk_i (
  .clk   (clk),
  .rst_n (rst_n),
  .start (start),
  .done  (done),
  .p     (p)
);

//--- verification/gf163_mult_tb.sv
// Testbench for the GF(2^163) digit-serial multiplier against a bit-serial reference model
`timescale 1ns/1ps
`include "gf_cfg.svh"

module gf163_mult_tb
  import gf_pkg::*;
();

  localparam logic [31:0] SEED     = 32'ha921_25ef;
  localparam int          TIMEOUT  = 200;
  localparam int          NUM_RAND = 20;
  localparam int          LATENCY  = `GF_NUM_DIGITS;
  localparam gf_elem_t    TAPS     = `GF_POLY_TAPS;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        start;
  gf_elem_t    a;
  gf_elem_t    b;
  gf_elem_t    p;
  logic        done;
  logic [31:0] lfsr;
  int          errors;
  int          err_mark;
  int          tests;
  int          tests_ok;

  gf163_mult dut_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .a     (a),
    .b     (b),
    .p     (p),
    .done  (done)
  );

  always #10 clk = ~clk;

  // Taps 32, 22, 2 and 1 give a maximal length sequence
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_elem(output gf_elem_t e);
    e = '0;
    for (int i = 0; i < `GF_M; i++) begin
      lfsr = lfsr_step(lfsr);
      e[i] = lfsr[0];
    end
  endtask

  // Horner's rule over the bits of y, one doubling and reduction per bit
  function automatic gf_elem_t ref_mul(input gf_elem_t x, input gf_elem_t y);
    gf_elem_t r;
    logic     carry;
    r = '0;
    for (int i = `GF_M - 1; i >= 0; i--) begin
      carry = r[`GF_M-1];
      r = r << 1;
      if (carry) begin
        r = r ^ TAPS;  // x^163 folds onto the low terms
      end
      if (y[i]) begin
        r = r ^ x;
      end
    end
    return r;
  endfunction

  function automatic int total_errors();
    return errors + int'(dut_i.chk_i.fail_cnt);
  endfunction

  task automatic check_elem(input string what, input gf_elem_t got, input gf_elem_t want);
    assert (got === want) else begin
      $display("MISMATCH at %0d ns: %s, got %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic check_int(input string what, input int got, input int want);
    assert (got == want) else begin
      $display("MISMATCH at %0d ns: %s, got %0d, expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (total_errors() == err_mark) begin
      tests_ok++;
      $display("ok      %s", name);
    end else begin
      $display("FAILED  %s, %0d errors", name, total_errors() - err_mark);
    end
    err_mark = total_errors();
  endtask

  task automatic start_op(input gf_elem_t x, input gf_elem_t y);
    @(posedge clk);
    start <= 1'b1;
    a     <= x;
    b     <= y;
  endtask

  // Counts rising edges after the one that first samples start, until done is seen
  task automatic wait_done(input logic scramble, output int edges);
    logic seen;
    seen  = 1'b0;
    edges = 0;
    @(posedge clk);
    while (!seen && edges < TIMEOUT) begin
      @(posedge clk);
      edges++;
      if (scramble && edges == 5) begin
        a <= ~a;  // The captured operands must not follow the inputs
        b <= ~b;
      end
      @(negedge clk);
      seen = done;
    end
    if (!seen) begin
      $display("Timeout at %0d ns: done did not rise within %0d cycles", $time, TIMEOUT);
      errors++;
    end
  endtask

  task automatic do_op(input string name, input gf_elem_t x, input gf_elem_t y,
                       input gf_elem_t want, input logic scramble);
    int edges;
    start_op(x, y);
    wait_done(scramble, edges);
    check_int({name, " latency"}, edges, LATENCY);
    check_elem({name, " product"}, p, want);
  endtask

  task automatic release_op();
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_int("done one edge after start low", int'(done), 0);
  endtask

  initial begin
    gf_elem_t x;
    gf_elem_t y;
    gf_elem_t r;
    rst_n    = 1'b0;
    start    = 1'b0;
    a        = '0;
    b        = '0;
    lfsr     = SEED;
    errors   = 0;
    err_mark = 0;
    tests    = 0;
    tests_ok = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_int("done after reset", int'(done), 0);
    check_elem("p after reset", p, '0);
    end_test("reset state");

    for (int n = 0; n < NUM_RAND; n++) begin
      random_elem(x);
      random_elem(y);
      do_op($sformatf("random pair %0d", n), x, y, ref_mul(x, y), 1'b0);
      release_op();
      end_test($sformatf("random pair %0d", n));
    end

    random_elem(x);
    do_op("a times one", x, gf_elem_t'(1), x, 1'b0);
    release_op();
    end_test("a times one");
    do_op("a times zero", x, '0, '0, 1'b0);
    release_op();
    end_test("a times zero");
    do_op("x^162 times x", gf_elem_t'(1) << (`GF_M - 1), gf_elem_t'(2),
          gf_elem_t'(8'hc9), 1'b0);
    release_op();
    end_test("x^162 times x");

    random_elem(x);
    random_elem(y);
    r = ref_mul(x, y);
    do_op("held start", x, y, r, 1'b0);
    repeat (5) begin
      @(posedge clk);
      @(negedge clk);
      check_int("done while start held", int'(done), 1);
      check_elem("p while start held", p, r);
    end
    release_op();
    check_elem("p after start low", p, r);
    end_test("done held with start");

    random_elem(x);
    random_elem(y);
    do_op("inputs changed", x, y, ref_mul(x, y), 1'b1);
    release_op();
    end_test("operands captured at start");

    random_elem(x);
    random_elem(y);
    do_op("first of two", x, y, ref_mul(x, y), 1'b0);
    @(posedge clk);
    start <= 1'b0;  // Sampled low on one edge only
    random_elem(x);
    random_elem(y);
    do_op("second of two", x, y, ref_mul(x, y), 1'b0);
    release_op();
    end_test("back to back");

    $display("%0d of %0d tests ok, %0d errors", tests_ok, tests, total_errors());
    if (total_errors() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
design/gf_pkg.sv
design/gf_digit_if.sv
design/gf_digit_sequencer.sv
design/gf_poly_reduce.sv
design/gf_digit_mac.sv
design/gf163_mult.sv
verification/gf163_mult_chk.sv
verification/gf163_mult_tb.sv

//--- Makefile
TOP := gf163_mult_tb

obj_dir/V$(TOP): compile.f $(wildcard include/*.svh design/*.sv verification/*.sv)
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@if ! grep -q "test passed" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
